//--- include/tbs_cfg.svh
/*
 * Scheduler sizing. TBS_CU_IDX_BITS must cover TBS_NUM_CU units and
 * the ID width sets the tracker scoreboard to 2**TBS_TBLOCK_ID_BITS entries
 */
`ifndef TBS_CFG_SVH
`define TBS_CFG_SVH

// Number of compute units behind the scheduler
`define TBS_NUM_CU 4
// Width of a unit index, log2 of the unit count
`define TBS_CU_IDX_BITS 2

// Program counter width of a block entry point
`define TBS_PC_WIDTH 16
// Data / parameter pointer width
`define TBS_ADDR_WIDTH 32

// Block index inside a thread group
`define TBS_TBLOCK_IDX_BITS 8
// Unique block identifier, sizes the in-flight scoreboard
`define TBS_TBLOCK_ID_BITS 8

`endif

//--- verilog/tbs_pkg.sv
/*
 * Shared types of the block scheduler.
 * Field widths come from the configuration macros.
 */
`include "tbs_cfg.svh"

package tbs_pkg;

    // ########################################
    // Scalar types
    // ########################################

    // Block identifier, unique while the block is in flight
    typedef logic [`TBS_TBLOCK_ID_BITS-1:0] tblock_id_t;

    // One bit per compute unit
    typedef logic [`TBS_NUM_CU-1:0] cu_mask_t;

    // ########################################
    // Descriptors
    // ########################################

    // Block launch request, 64 bits with the default sizing
    typedef struct packed {
        logic [`TBS_PC_WIDTH-1:0]        pc;         // Entry point
        logic [`TBS_ADDR_WIDTH-1:0]      dp_addr;    // Data / parameter pointer
        logic [`TBS_TBLOCK_IDX_BITS-1:0] tblock_idx; // Used for thread id math
        tblock_id_t                      tblock_id;
    } alloc_desc_t;

    // Block completion report
    typedef struct packed {
        tblock_id_t                  tblock_id;
        logic [`TBS_CU_IDX_BITS-1:0] cu_idx;    // Unit that finished the block
    } done_desc_t;

    // ########################################
    // State encodings
    // ########################################

    // Completion output register
    typedef enum logic {
        HOLD_EMPTY = 1'b0,
        HOLD_FULL  = 1'b1
    } hold_state_e;

endpackage : tbs_pkg

//--- verilog/alloc_distributor.sv
/*
 * Sends each accepted block to the lowest-indexed unit with a free warp.
 * Units have no ready, a unit that reports free must take the pulse.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module alloc_distributor import tbs_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // Upstream request
    input  logic        allocate_valid_i,
    input  alloc_desc_t allocate_desc_i,
    output logic        allocate_ready_o,
    output logic        warp_free_o,

    // Per-unit warp availability
    input  cu_mask_t    cu_warp_free_i,

    // Tracker handshake
    input  logic        id_busy_i,
    output logic        alloc_fire_o,
    output tblock_id_t  alloc_id_o,

    // Launch pulse to the units
    output cu_mask_t    cu_alloc_o,
    output alloc_desc_t cu_alloc_desc_o
);
    localparam int unsigned num_cu = `TBS_NUM_CU;

    cu_mask_t    sel;
    logic        fire;
    cu_mask_t    cu_alloc_q;
    alloc_desc_t desc_q;

    // ########################################
    // Unit selection
    // ########################################

    // Find first free unit, lowest index wins
    always_comb begin : first_free
        sel = '0;
        for (int unsigned cu = 0; cu < num_cu; cu++) begin
            if (cu_warp_free_i[cu] && (sel == '0)) begin
                sel[cu] = 1'b1;
            end
        end
    end : first_free

    assign warp_free_o = |cu_warp_free_i;

    // Accept only with a free slot and an id that is not already running
    assign allocate_ready_o = warp_free_o & ~id_busy_i;
    assign fire             = allocate_valid_i & allocate_ready_o;

    // Tracker marks the id busy on this same edge
    assign alloc_fire_o = fire;
    assign alloc_id_o   = allocate_desc_i.tblock_id;

    // ########################################
    // Launch register
    // ########################################

    // Selection lives for exactly one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cu_alloc_q <= '0;
        end else begin
            cu_alloc_q <= fire ? sel : '0;
        end
    end

    // Payload only, qualified by the pulse
    always_ff @(posedge clk_i) begin
        if (fire) begin
            desc_q <= allocate_desc_i;
        end
    end

    assign cu_alloc_o      = cu_alloc_q;
    assign cu_alloc_desc_o = desc_q;

    // Pulse follows a transfer and hits one unit that was free at that edge
    assert property (@(posedge clk_i) disable iff (reset_i)
        (cu_alloc_o != '0) |->
            $onehot(cu_alloc_o) && $past(fire) &&
            ((cu_alloc_o & ~$past(cu_warp_free_i)) == '0))
        else $error("cu_alloc_o not a single free unit after a transfer");

endmodule : alloc_distributor

//--- verilog/done_arbiter.sv
/*
 * Round-robin merge of unit completions into one registered output.
 * A new grant only when the output slot is empty or drains this cycle.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module done_arbiter import tbs_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,

    // Per-unit completion requests
    input  cu_mask_t                    cu_done_i,
    input  tblock_id_t [`TBS_NUM_CU-1:0] cu_done_id_i,
    output cu_mask_t                    cu_done_ready_o,

    // Merged completion stream
    output logic                        tblock_done_o,
    output done_desc_t                  tblock_done_desc_o,
    input  logic                        tblock_done_ready_i,

    // Tracker release
    output logic                        done_fire_o,
    output tblock_id_t                  done_id_o
);
    localparam int unsigned num_cu = `TBS_NUM_CU;

    hold_state_e                 hold_q;
    done_desc_t                  desc_q;
    logic [`TBS_CU_IDX_BITS-1:0] rr_ptr_q;   // First unit looked at
    logic [`TBS_CU_IDX_BITS-1:0] grant_idx;
    logic                        found;
    logic                        can_load;
    logic                        load;

    // ########################################
    // Round-robin search
    // ########################################

    always_comb begin : rr_search
        logic [`TBS_CU_IDX_BITS-1:0] idx;
        found     = 1'b0;
        grant_idx = '0;
        for (int unsigned off = 0; off < num_cu; off++) begin
            idx = `TBS_CU_IDX_BITS'((rr_ptr_q + off) % num_cu);
            if (!found && cu_done_i[idx]) begin
                found     = 1'b1;
                grant_idx = idx;
            end
        end
    end : rr_search

    // Slot is free or its content leaves on this edge
    assign can_load = (hold_q == HOLD_EMPTY) || tblock_done_ready_i;
    assign load     = found && can_load;

    // Ready only to the winner, nothing under back-pressure
    assign cu_done_ready_o = load ? (cu_mask_t'(1) << grant_idx) : '0;

    // ########################################
    // Output hold register
    // ########################################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hold_q   <= HOLD_EMPTY;
            rr_ptr_q <= '0;
        end else if (load) begin
            hold_q   <= HOLD_FULL;
            // Next search starts one past the winner
            rr_ptr_q <= `TBS_CU_IDX_BITS'((grant_idx + 1) % num_cu);
        end else if (done_fire_o) begin
            hold_q   <= HOLD_EMPTY;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            desc_q.tblock_id <= cu_done_id_i[grant_idx];
            desc_q.cu_idx    <= grant_idx;
        end
    end

    assign tblock_done_o      = (hold_q == HOLD_FULL);
    assign tblock_done_desc_o = desc_q;

    // Release the id when the downstream takes it
    assign done_fire_o = tblock_done_o & tblock_done_ready_i;
    assign done_id_o   = desc_q.tblock_id;

    // Grant is single and goes to a requesting unit
    assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(cu_done_ready_o) && ((cu_done_ready_o & ~cu_done_i) == '0))
        else $error("cu_done_ready_o grants more than one or an idle unit");

    // Stalled output keeps its content
    assert property (@(posedge clk_i) disable iff (reset_i)
        (tblock_done_o && !tblock_done_ready_i) |=>
            tblock_done_o && $stable(tblock_done_desc_o))
        else $error("tblock_done_desc_o changed under back-pressure");

endmodule : done_arbiter

//--- verilog/tblock_tracker.sv
/*
 * Scoreboard of in-flight block ids with a running count.
 * A completion for an id that is not busy sets a sticky error.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module tblock_tracker import tbs_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Dispatch side
    input  logic                         alloc_fire_i,
    input  tblock_id_t                   alloc_id_i,

    // Completion side
    input  logic                         done_fire_i,
    input  tblock_id_t                   done_id_i,

    // Lookup for the pending request
    input  tblock_id_t                   query_id_i,
    output logic                         id_busy_o,

    // Status
    output logic [`TBS_TBLOCK_ID_BITS:0] inflight_count_o,
    output logic                         done_error_o
);
    localparam int unsigned num_ids = 1 << `TBS_TBLOCK_ID_BITS;

    logic [num_ids-1:0]             busy_q;
    logic [`TBS_TBLOCK_ID_BITS:0]   count_q;
    logic                           error_q;
    logic                           done_hit;
    logic                           done_miss;

    // ########################################
    // Lookup
    // ########################################

    assign id_busy_o = busy_q[query_id_i];

    // Completion matches a live entry or not
    assign done_hit  = done_fire_i &  busy_q[done_id_i];
    assign done_miss = done_fire_i & ~busy_q[done_id_i];

    // ########################################
    // Scoreboard and counter
    // ########################################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q  <= '0;
            count_q <= '0;
            error_q <= 1'b0;
        end else begin
            if (alloc_fire_i) begin
                busy_q[alloc_id_i] <= 1'b1;
            end
            if (done_hit) begin
                busy_q[done_id_i] <= 1'b0;
            end

            // Both sides at once leave the count alone
            case ({alloc_fire_i, done_hit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // Sticky until reset
            if (done_miss) begin
                error_q <= 1'b1;
            end
        end
    end

    assign inflight_count_o = count_q;
    assign done_error_o     = error_q;

    // Dispatcher must never reuse a running id
    assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_fire_i |-> !busy_q[alloc_id_i])
        else $error("allocation of id %0d which is already in flight", alloc_id_i);

endmodule : tblock_tracker

//--- verilog/tblock_scheduler.sv
/*
 * Block scheduler top: dispatch, completion merge and id tracking.
 * The request id must stay unique until its completion leaves the output.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module tblock_scheduler import tbs_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // New block request
    input  logic                         allocate_valid_i,
    input  alloc_desc_t                  allocate_desc_i,
    output logic                         allocate_ready_o,
    output logic                         warp_free_o,

    // Launch to the compute units
    input  cu_mask_t                     cu_warp_free_i,
    output cu_mask_t                     cu_alloc_o,
    output alloc_desc_t                  cu_alloc_desc_o,

    // Completion from the compute units
    input  cu_mask_t                     cu_done_i,
    input  tblock_id_t [`TBS_NUM_CU-1:0] cu_done_id_i,
    output cu_mask_t                     cu_done_ready_o,

    // Merged completion stream
    output logic                         tblock_done_o,
    output done_desc_t                   tblock_done_desc_o,
    input  logic                         tblock_done_ready_i,

    // Status
    output logic [`TBS_TBLOCK_ID_BITS:0] inflight_count_o,
    output logic                         done_error_o
);
    logic       alloc_fire;
    tblock_id_t alloc_id;
    logic       done_fire;
    tblock_id_t done_id;
    logic       id_busy;

    // ########################################
    // Dispatch
    // ########################################

    alloc_distributor i_alloc_distributor (
        .clk_i           ( clk_i            ),
        .reset_i         ( reset_i          ),
        .allocate_valid_i( allocate_valid_i ),
        .allocate_desc_i ( allocate_desc_i  ),
        .allocate_ready_o( allocate_ready_o ),
        .warp_free_o     ( warp_free_o      ),
        .cu_warp_free_i  ( cu_warp_free_i   ),
        .id_busy_i       ( id_busy          ),
        .alloc_fire_o    ( alloc_fire       ),
        .alloc_id_o      ( alloc_id         ),
        .cu_alloc_o      ( cu_alloc_o       ),
        .cu_alloc_desc_o ( cu_alloc_desc_o  )
    );

    // ########################################
    // Completion merge
    // ########################################

    done_arbiter i_done_arbiter (
        .clk_i              ( clk_i               ),
        .reset_i            ( reset_i             ),
        .cu_done_i          ( cu_done_i           ),
        .cu_done_id_i       ( cu_done_id_i        ),
        .cu_done_ready_o    ( cu_done_ready_o     ),
        .tblock_done_o      ( tblock_done_o       ),
        .tblock_done_desc_o ( tblock_done_desc_o  ),
        .tblock_done_ready_i( tblock_done_ready_i ),
        .done_fire_o        ( done_fire           ),
        .done_id_o          ( done_id             )
    );

    // ########################################
    // In-flight tracking
    // ########################################

    // Query with the id currently offered upstream
    tblock_tracker i_tblock_tracker (
        .clk_i           ( clk_i                     ),
        .reset_i         ( reset_i                   ),
        .alloc_fire_i    ( alloc_fire                ),
        .alloc_id_i      ( alloc_id                  ),
        .done_fire_i     ( done_fire                 ),
        .done_id_i       ( done_id                   ),
        .query_id_i      ( allocate_desc_i.tblock_id ),
        .id_busy_o       ( id_busy                   ),
        .inflight_count_o( inflight_count_o          ),
        .done_error_o    ( done_error_o              )
    );

endmodule : tblock_scheduler

//--- tb/tb_cu_model.sv
/*
 * Behavioural compute units, two warp slots each, state moves on the falling edge.
 * Injected completions always leave through unit 0.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module tb_cu_model import tbs_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  cu_mask_t                     cu_alloc_i,
    input  alloc_desc_t                  cu_alloc_desc_i,
    input  cu_mask_t                     cu_done_ready_i,
    input  logic                         inject_i,
    input  tblock_id_t                   inject_id_i,
    output cu_mask_t                     cu_warp_free_o,
    output cu_mask_t                     cu_done_o,
    output tblock_id_t [`TBS_NUM_CU-1:0] cu_done_id_o
);
    localparam int num_cu = `TBS_NUM_CU;

    logic [1:0] slot_used [num_cu] = '{default: 2'b00};
    tblock_id_t slot_id   [num_cu][2];
    int         slot_wait [num_cu][2];
    // Slot shown on done, -1 for none, 2 for the injected id
    int         pres_slot [num_cu] = '{default: -1};
    cu_mask_t   taken_q = '0;
    logic       inject_q = 1'b0;
    tblock_id_t inject_id_q;
    logic       inj_pend = 1'b0;

    // Handshakes complete on the rising edge
    always @(posedge clk_i) begin
        taken_q     <= cu_done_o & cu_done_ready_i;
        inject_q    <= inject_i;
        inject_id_q <= inject_id_i;
    end

    always @(negedge clk_i) begin
        logic placed;
        if (reset_i) begin
            for (int cu = 0; cu < num_cu; cu++) begin
                slot_used[cu] = 2'b00;
                pres_slot[cu] = -1;
            end
            inj_pend = 1'b0;
        end else begin
            if (inject_q) begin
                inj_pend = 1'b1;
            end
            for (int cu = 0; cu < num_cu; cu++) begin
                // Retire what the arbiter took
                if (taken_q[cu]) begin
                    if (pres_slot[cu] == 2) begin
                        inj_pend = 1'b0;
                    end else begin
                        slot_used[cu][pres_slot[cu]] = 1'b0;
                    end
                    pres_slot[cu] = -1;
                end
                for (int s = 0; s < 2; s++) begin
                    if (slot_used[cu][s] && slot_wait[cu][s] > 0) begin
                        slot_wait[cu][s]--;
                    end
                end
                // New block into the first empty slot, random run time
                placed = 1'b0;
                for (int s = 0; s < 2; s++) begin
                    if (cu_alloc_i[cu] && !slot_used[cu][s] && !placed) begin
                        slot_used[cu][s] = 1'b1;
                        slot_id[cu][s]   = cu_alloc_desc_i.tblock_id;
                        slot_wait[cu][s] = 1 + int'($urandom % 12);
                        placed           = 1'b1;
                    end
                end
                // Present a finished block, held until taken
                if (pres_slot[cu] < 0) begin
                    if (cu == 0 && inj_pend) begin
                        pres_slot[cu] = 2;
                    end else begin
                        for (int s = 0; s < 2; s++) begin
                            if (slot_used[cu][s] && slot_wait[cu][s] == 0 && pres_slot[cu] < 0) begin
                                pres_slot[cu] = s;
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        for (int cu = 0; cu < num_cu; cu++) begin
            cu_warp_free_o[cu] = ~&slot_used[cu];
            cu_done_o[cu]      = (pres_slot[cu] >= 0);
            if (pres_slot[cu] == 2) begin
                cu_done_id_o[cu] = inject_id_q;
            end else begin
                cu_done_id_o[cu] = slot_id[cu][pres_slot[cu][0]];
            end
        end
    end

endmodule : tb_cu_model

//--- tb/tb_tblock_scheduler.sv
/*
 * Testbench of the block scheduler, concurrent assertions do the checks.
 * Random ids stay below 128 so the stray completion id is never allocated.
 */
`timescale 1ns/10ps
`include "tbs_cfg.svh"

module tb_tblock_scheduler import tbs_pkg::*; ();
    localparam int         num_cu        = `TBS_NUM_CU;
    localparam int         num_ids       = 1 << `TBS_TBLOCK_ID_BITS;
    localparam int         alloc_timeout = 400;
    localparam int         idle_timeout  = 1000;
    localparam int         error_timeout = 50;
    localparam tblock_id_t stray_id      = tblock_id_t'(8'hc3);

    logic                         clk_i;
    logic                         reset_i;
    logic                         allocate_valid_i;
    alloc_desc_t                  allocate_desc_i;
    logic                         allocate_ready_o;
    logic                         warp_free_o;
    cu_mask_t                     cu_warp_free_i;
    cu_mask_t                     cu_alloc_o;
    alloc_desc_t                  cu_alloc_desc_o;
    cu_mask_t                     cu_done_i;
    tblock_id_t [num_cu-1:0]      cu_done_id_i;
    cu_mask_t                     cu_done_ready_o;
    logic                         tblock_done_o;
    done_desc_t                   tblock_done_desc_o;
    logic                         tblock_done_ready_i;
    logic [`TBS_TBLOCK_ID_BITS:0] inflight_count_o;
    logic                         done_error_o;
    logic                         inject;
    tblock_id_t                   inject_id;

    // ########################################
    // Reference state
    // ########################################

    logic [num_ids-1:0]          ref_busy;
    logic [`TBS_CU_IDX_BITS-1:0] ref_cu [num_ids];
    int                          ref_count;
    int                          rr_ptr;
    cu_mask_t                    exp_grant;
    logic                        alloc_fire_q;
    cu_mask_t                    exp_sel_q;
    alloc_desc_t                 exp_desc_q;
    logic                        bp_mode = 1'b0;
    logic                        stray_phase = 1'b0;
    logic                        hung = 1'b0;
    int                          errors = 0;
    int                          tests_run = 0;

    tblock_scheduler DUT (.*);

    tb_cu_model i_cu_model (
        .clk_i          ( clk_i           ),
        .reset_i        ( reset_i         ),
        .cu_alloc_i     ( cu_alloc_o      ),
        .cu_alloc_desc_i( cu_alloc_desc_o ),
        .cu_done_ready_i( cu_done_ready_o ),
        .inject_i       ( inject          ),
        .inject_id_i    ( inject_id       ),
        .cu_warp_free_o ( cu_warp_free_i  ),
        .cu_done_o      ( cu_done_i       ),
        .cu_done_id_o   ( cu_done_id_i    )
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Index of the lowest set bit, -1 if none
    function automatic int lowest_set(cu_mask_t mask);
        int pick;
        pick = -1;
        for (int cu = num_cu - 1; cu >= 0; cu--) begin
            if (mask[cu]) pick = cu;
        end
        return pick;
    endfunction

    // Round-robin winner, first requester at or after the pointer
    always_comb begin : rr_model
        int idx;
        exp_grant = '0;
        for (int off = num_cu - 1; off >= 0; off--) begin
            idx = (rr_ptr + off) % num_cu;
            if (cu_done_i[idx]) exp_grant = cu_mask_t'(1) << idx;
        end
    end : rr_model

    always @(posedge clk_i) begin : scoreboard
        logic fire_in;
        logic fire_out;
        fire_in  = allocate_valid_i && allocate_ready_o;
        fire_out = tblock_done_o && tblock_done_ready_i && ref_busy[tblock_done_desc_o.tblock_id];
        if (reset_i) begin
            alloc_fire_q <= 1'b0;
            ref_busy     <= '0;
            ref_count    <= 0;
            rr_ptr       <= 0;
        end else begin
            alloc_fire_q <= fire_in;
            if (fire_in) begin
                ref_busy[allocate_desc_i.tblock_id] <= 1'b1;
                ref_cu[allocate_desc_i.tblock_id] <=
                    `TBS_CU_IDX_BITS'(lowest_set(cu_warp_free_i));
                exp_sel_q  <= cu_mask_t'(1) << lowest_set(cu_warp_free_i);
                exp_desc_q <= allocate_desc_i;
            end
            if (fire_out) begin
                ref_busy[tblock_done_desc_o.tblock_id] <= 1'b0;
            end
            ref_count <= ref_count + int'(fire_in) - int'(fire_out);
            // Pointer moves past the expected winner whenever the slot can load
            if ((!tblock_done_o || tblock_done_ready_i) && exp_grant != '0) begin
                rr_ptr <= (lowest_set(exp_grant) + 1) % num_cu;
            end
        end
    end : scoreboard

    // ########################################
    // Checks
    // ########################################

    // Launch pulse goes to the lowest unit free at the transfer
    assert property (@(posedge clk_i) disable iff (reset_i)
        cu_alloc_o == (alloc_fire_q ? exp_sel_q : cu_mask_t'(0)) &&
        (!alloc_fire_q || cu_alloc_desc_o == exp_desc_q))
        else begin
            errors++;
            $display("MISMATCH %0t: launch %b desc %h, expected %b desc %h",
                     $time, cu_alloc_o, cu_alloc_desc_o, exp_sel_q, exp_desc_q);
        end

    // Ready needs a free unit and an id that is not in flight
    assert property (@(posedge clk_i) disable iff (reset_i)
        allocate_ready_o == (|cu_warp_free_i && !ref_busy[allocate_desc_i.tblock_id]))
        else begin
            errors++;
            $display("MISMATCH %0t: allocate_ready_o %b for id %0d, free units %b",
                     $time, allocate_ready_o, allocate_desc_i.tblock_id, cu_warp_free_i);
        end

    // Summary flag is set while any unit has a free warp
    assert property (@(posedge clk_i) disable iff (reset_i)
        warp_free_o == |cu_warp_free_i)
        else begin
            errors++;
            $display("MISMATCH %0t: warp_free_o %b, free units %b",
                     $time, warp_free_o, cu_warp_free_i);
        end

    // Each completion names a live id and the unit it ran on
    assert property (@(posedge clk_i) disable iff (reset_i)
        (tblock_done_o && tblock_done_ready_i && !stray_phase) |->
            ref_busy[tblock_done_desc_o.tblock_id] &&
            tblock_done_desc_o.cu_idx == ref_cu[tblock_done_desc_o.tblock_id])
        else begin
            errors++;
            $display("MISMATCH %0t: completion id %0d from unit %0d not expected",
                     $time, tblock_done_desc_o.tblock_id, tblock_done_desc_o.cu_idx);
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        int'(inflight_count_o) == ref_count)
        else begin
            errors++;
            $display("MISMATCH %0t: inflight_count_o %0d, expected %0d",
                     $time, inflight_count_o, ref_count);
        end

    // Grant follows round-robin, none while the output stalls
    assert property (@(posedge clk_i) disable iff (reset_i)
        cu_done_ready_o ==
            ((!tblock_done_o || tblock_done_ready_i) ? exp_grant : cu_mask_t'(0)))
        else begin
            errors++;
            $display("MISMATCH %0t: cu_done_ready_o %b, expected %b",
                     $time, cu_done_ready_o, exp_grant);
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        (tblock_done_o && !tblock_done_ready_i) |=>
            tblock_done_o && $stable(tblock_done_desc_o))
        else begin
            errors++;
            $display("MISMATCH %0t: completion output changed while stalled", $time);
        end

    // Error flag only after the stray completion
    assert property (@(posedge clk_i) disable iff (reset_i)
        stray_phase || !done_error_o)
        else begin
            errors++;
            $display("MISMATCH %0t: done_error_o set without a stray completion", $time);
        end

    // Once set the flag holds until reset
    assert property (@(posedge clk_i) disable iff (reset_i)
        done_error_o |=> done_error_o)
        else begin
            errors++;
            $display("MISMATCH %0t: done_error_o dropped before reset", $time);
        end

    // ########################################
    // Stimulus
    // ########################################

    // Output ready, random or in stall stretches
    initial begin : done_ready_driver
        int stall_left;
        stall_left          = 0;
        tblock_done_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (!bp_mode) begin
                tblock_done_ready_i = ($urandom % 4) != 0;
            end else if (stall_left > 0) begin
                tblock_done_ready_i = 1'b0;
                stall_left--;
            end else begin
                tblock_done_ready_i = 1'b1;
                if ($urandom % 3 == 0) stall_left = 2 + int'($urandom % 10);
            end
        end
    end : done_ready_driver

    task automatic send_block(input alloc_desc_t desc);
        int waited;
        allocate_valid_i = 1'b1;
        allocate_desc_i  = desc;
        waited           = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!alloc_fire_q && waited < alloc_timeout);
        allocate_valid_i = 1'b0;
        if (!alloc_fire_q) begin
            $display("TIMEOUT: block id %0d was not accepted within %0d cycles",
                     desc.tblock_id, alloc_timeout);
            hung = 1'b1;
        end
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        while ((ref_count != 0 || tblock_done_o) && waited < idle_timeout) begin
            @(negedge clk_i);
            waited++;
        end
        if (ref_count != 0 || tblock_done_o) begin
            $display("TIMEOUT: %s left %0d blocks unfinished after %0d cycles",
                     name, ref_count, idle_timeout);
            hung = 1'b1;
        end
    endtask

    task automatic run_traffic(input string name, input logic stall, input int blocks);
        int          start_errors;
        alloc_desc_t desc;
        tblock_id_t  last_id;
        start_errors = errors;
        bp_mode      = stall;
        last_id      = '0;
        tests_run++;
        for (int n = 0; n < blocks && !hung; n++) begin
            desc.pc         = 16'($urandom);
            desc.dp_addr    = $urandom;
            desc.tblock_idx = 8'(n);
            // Now and then reoffer the last id while it may still run
            desc.tblock_id  = (n % 8 == 3) ? last_id : tblock_id_t'($urandom % 128);
            last_id         = desc.tblock_id;
            send_block(desc);
        end
        if (!hung) wait_idle(name);
        $display("test %s finished, %0d failed checks", name, errors - start_errors);
    endtask

    task automatic inject_stray();
        int start_errors;
        int waited;
        start_errors = errors;
        bp_mode      = 1'b0;
        stray_phase  = 1'b1;
        tests_run++;
        inject_id    = stray_id;
        inject       = 1'b1;
        @(negedge clk_i);
        inject = 1'b0;
        waited = 0;
        while (!done_error_o && waited < error_timeout) begin
            @(negedge clk_i);
            waited++;
        end
        if (!done_error_o) begin
            $display("TIMEOUT: done_error_o not raised within %0d cycles", error_timeout);
            hung = 1'b1;
        end else begin
            // Flag must survive idle cycles, then reset clears it
            repeat (20) @(negedge clk_i);
            reset_i = 1'b1;
            repeat (4) @(negedge clk_i);
            reset_i     = 1'b0;
            stray_phase = 1'b0;
            repeat (5) @(negedge clk_i);
        end
        $display("test stray done finished, %0d failed checks", errors - start_errors);
    endtask

    initial begin : main
        void'($urandom(32'h2a10_e35d));
        reset_i          = 1'b1;
        allocate_valid_i = 1'b0;
        allocate_desc_i  = '0;
        inject           = 1'b0;
        inject_id        = '0;
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
        run_traffic("dispatch", 1'b0, 80);
        if (!hung) run_traffic("back-pressure", 1'b1, 80);
        if (!hung) inject_stray();
        $display("tests run %0d, failed checks %0d, timeouts %0d", tests_run, errors, int'(hung));
        if (errors == 0 && !hung) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end : main

endmodule : tb_tblock_scheduler

//--- files.f
+incdir+include
verilog/tbs_pkg.sv
verilog/alloc_distributor.sv
verilog/done_arbiter.sv
verilog/tblock_tracker.sv
verilog/tblock_scheduler.sv
tb/tb_cu_model.sv
tb/tb_tblock_scheduler.sv

//--- Makefile
# Verilator flow for the block scheduler testbench

VERILATOR ?= verilator
TOP       := tb_tblock_scheduler
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides, the simulator exit code does not
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
